/* design/dbg_settings.svh */
// Chain lengths, field widths and module IDs of the debug unit
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

//////////////////////////////
// Chain geometry
//////////////////////////////

// Main data register: sel flag, 2 bit id/op, 16 bit addr, 32 bit data
`define DBG_DATAREG_LEN   51
`define DBG_MODULE_ID_LEN 2
`define DBG_ADDR_W        16
`define DBG_DATA_W        32
// Response: rdata, err, busy
`define DBG_RESP_LEN      34

//////////////////////////////
// Module IDs
//////////////////////////////

`define DBG_ID_RESERVED 2'd0
`define DBG_ID_BUS      2'd1
// Decoded but not built
`define DBG_ID_CPU      2'd2
`define DBG_ID_JSP      2'd3

`endif

/* design/dbg_pkg.sv */
// Debug package: bus opcode enum, command union views and response struct
`include "dbg_settings.svh"
`default_nettype none

package dbg_pkg;

  // Bus command opcodes
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2,
    OP_RSVD  = 2'd3
  } dbg_op_e;

  // Chain word seen as a module select
  typedef struct packed {
    logic                                           sel;
    logic [`DBG_MODULE_ID_LEN-1:0]                  module_id;
    logic [`DBG_DATAREG_LEN-`DBG_MODULE_ID_LEN-2:0] pad;
  } dbg_sel_cmd_t;

  // Same word seen as a bus command
  typedef struct packed {
    logic                   sel;
    dbg_op_e                op;
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } dbg_bus_cmd_t;

  // Both views overlay the 51 bit chain word
  typedef union packed {
    dbg_sel_cmd_t sel_view;
    dbg_bus_cmd_t bus_view;
  } dbg_cmd_u;

  // Busy in bit 0, shifted out first
  typedef struct packed {
    logic [`DBG_DATA_W-1:0] rdata;
    logic                   err;
    logic                   busy;
  } dbg_resp_t;

endpackage

`default_nettype wire

/* design/dbg_chain_in.sv */
// Main data register shift chain and module select register
`include "dbg_settings.svh"
`default_nettype none

module dbg_chain_in
  import dbg_pkg::*;
(
  // JTAG clock and test logic reset
  input  wire                           tck_i,
  input  wire                           tlr_i,
  input  wire                           tdi_i,
  // Decoded TAP states
  input  wire                           debug_select_i,
  input  wire                           shift_dr_i,
  input  wire                           update_dr_i,
  // Busy module holds the current selection
  input  wire                           inhibit_i,
  // Chain word and current module
  output dbg_cmd_u                      cmd_o,
  output logic [`DBG_MODULE_ID_LEN-1:0] module_id_o
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Raw shift chain
  logic [`DBG_DATAREG_LEN-1:0]   shift_q;
  // Latched module ID
  logic [`DBG_MODULE_ID_LEN-1:0] module_id_q;
  // Chain word through the union
  dbg_cmd_u                      cmd;
  // Word is addressed to the select logic
  logic                          select_cmd;

  //////////////////////////////
  // Shift chain
  //////////////////////////////

  assign cmd        = dbg_cmd_u'(shift_q);
  assign select_cmd = cmd.sel_view.sel;

  // TDI enters at the MSB, LSB falls off
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      shift_q <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      shift_q <= {tdi_i, shift_q[`DBG_DATAREG_LEN-1:1]};
    end
  end

  //////////////////////////////
  // Module select
  //////////////////////////////

  // Reserved module after reset
  // New ID only with the select flag set and nobody busy
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      module_id_q <= `DBG_ID_RESERVED;
    end else if (debug_select_i && update_dr_i && select_cmd && !inhibit_i) begin
      module_id_q <= cmd.sel_view.module_id;
    end
  end

  // Outputs
  assign cmd_o       = cmd;
  assign module_id_o = module_id_q;

endmodule

`default_nettype wire

/* design/dbg_bus_module.sv */
// Bus debug module: command latch and Wishbone classic master FSM
`include "dbg_settings.svh"
`default_nettype none

module dbg_bus_module
  import dbg_pkg::*;
(
  input  wire                           tck_i,
  input  wire                           tlr_i,
  // TAP state and chain word
  input  wire                           update_dr_i,
  input  wire                           debug_select_i,
  input  wire [`DBG_MODULE_ID_LEN-1:0]  module_id_i,
  input  wire dbg_cmd_u                 cmd_i,
  // Status back to the chain logic
  output logic                          busy_o,
  output dbg_resp_t                     resp_o,
  // Wishbone classic master
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [`DBG_ADDR_W-1:0]        wb_adr_o,
  output logic [`DBG_DATA_W-1:0]        wb_dat_o,
  output logic [`DBG_DATA_W/8-1:0]      wb_sel_o,
  input  wire  [`DBG_DATA_W-1:0]        wb_dat_i,
  input  wire                           wb_ack_i,
  input  wire                           wb_err_i
);

  // FSM encoding
  localparam logic IDLE   = 1'b0;
  localparam logic ACTIVE = 1'b1;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic                   state_q;
  logic                   active;
  logic                   bus_sel;
  logic                   xfer_op;
  logic                   accept;
  logic                   done;
  // Latched command
  logic                   we_q;
  logic [`DBG_ADDR_W-1:0] adr_q;
  logic [`DBG_DATA_W-1:0] dat_q;
  // Result of the last transfer
  logic [`DBG_DATA_W-1:0] rdata_q;
  logic                   err_q;

  //////////////////////////////
  // Command decode
  //////////////////////////////

  assign active  = (state_q == ACTIVE);
  assign bus_sel = (module_id_i == `DBG_ID_BUS);
  // Only write and read start a cycle
  assign xfer_op = (cmd_i.bus_view.op == OP_WRITE) || (cmd_i.bus_view.op == OP_READ);
  // Commands while busy are dropped
  assign accept  = debug_select_i && update_dr_i && bus_sel && !cmd_i.bus_view.sel &&
                   xfer_op && !active;
  // Slave ends the cycle with ack or err
  assign done    = active && (wb_ack_i || wb_err_i);

  //////////////////////////////
  // Wishbone FSM
  //////////////////////////////

  // Cycle starts on the accepting edge, ends on the edge that sees ack
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (accept) state_q <= ACTIVE;
        ACTIVE:  if (done) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Write direction of the latched command
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      we_q <= 1'b0;
    end else if (accept) begin
      we_q <= (cmd_i.bus_view.op == OP_WRITE);
    end
  end

  // Address and write data
  always_ff @(posedge tck_i) begin
    if (accept) begin
      adr_q <= cmd_i.bus_view.addr;
      dat_q <= cmd_i.bus_view.wdata;
    end
  end

  //////////////////////////////
  // Result
  //////////////////////////////

  // Err sticks until the next accepted command
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      if (accept) begin
        err_q <= 1'b0;
      end else if (active && wb_err_i) begin
        err_q <= 1'b1;
      end
      // Read data on ack only
      if (active && wb_ack_i && !we_q) begin
        rdata_q <= wb_dat_i;
      end
    end
  end

  // Bus outputs, full word lanes
  assign wb_cyc_o = active;
  assign wb_stb_o = active;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = {(`DBG_DATA_W/8){active}};

  // Busy also inhibits module select
  assign busy_o       = active;
  assign resp_o.rdata = rdata_q;
  assign resp_o.err   = err_q;
  assign resp_o.busy  = active;

endmodule

`default_nettype wire

/* design/dbg_chain_out.sv */
// Response capture and shift-out register with the TDO select
`include "dbg_settings.svh"
`default_nettype none

module dbg_chain_out
  import dbg_pkg::*;
(
  // JTAG clock and test logic reset
  input  wire                          tck_i,
  input  wire                          tlr_i,
  // Decoded TAP states
  input  wire                          debug_select_i,
  input  wire                          capture_dr_i,
  input  wire                          shift_dr_i,
  // Selected module and its response
  input  wire [`DBG_MODULE_ID_LEN-1:0] module_id_i,
  input  wire dbg_resp_t               resp_i,
  // Serial data out
  output logic                         tdo_o
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Output chain, bit 0 drives TDO
  logic [`DBG_RESP_LEN-1:0] resp_q;
  // Bus module owns the chain
  logic                     bus_sel;
  logic                     capture;
  logic                     shift;

  assign bus_sel = (module_id_i == `DBG_ID_BUS);
  assign capture = debug_select_i && capture_dr_i && bus_sel;
  assign shift   = debug_select_i && shift_dr_i;

  //////////////////////////////
  // Capture and shift
  //////////////////////////////

  // Busy first, then err, then rdata LSB first
  // Zeros fill from the top
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      resp_q <= '0;
    end else if (capture) begin
      resp_q <= resp_i;
    end else if (shift) begin
      resp_q <= {1'b0, resp_q[`DBG_RESP_LEN-1:1]};
    end
  end

  //////////////////////////////
  // TDO select
  //////////////////////////////

  // CPU and serial port not built
  // Reserved module returns 0 as well
  always_comb begin
    case (module_id_i)
      `DBG_ID_BUS: tdo_o = resp_q[0];
      `DBG_ID_CPU: tdo_o = 1'b0;
      `DBG_ID_JSP: tdo_o = 1'b0;
      default:     tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/dbg_top.sv */
// Debug unit top level: input chain, bus debug module, output chain
`include "dbg_settings.svh"
`default_nettype none

module dbg_top
  import dbg_pkg::*;
(
  // JTAG clock, reset and data
  input  wire                      tck_i,
  input  wire                      tlr_i,
  input  wire                      tdi_i,
  output logic                     tdo_o,
  // TAP states from the external controller
  input  wire                      debug_select_i,
  input  wire                      shift_dr_i,
  input  wire                      update_dr_i,
  input  wire                      capture_dr_i,
  // Wishbone classic master
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [`DBG_ADDR_W-1:0]   wb_adr_o,
  output logic [`DBG_DATA_W-1:0]   wb_dat_o,
  output logic [`DBG_DATA_W/8-1:0] wb_sel_o,
  input  wire  [`DBG_DATA_W-1:0]   wb_dat_i,
  input  wire                      wb_ack_i,
  input  wire                      wb_err_i
);

  //////////////////////////////
  // Interconnect
  //////////////////////////////

  dbg_cmd_u                      cmd;
  logic [`DBG_MODULE_ID_LEN-1:0] module_id;
  // Busy doubles as select inhibit
  logic                          busy;
  dbg_resp_t                     resp;

  // Input side
  dbg_chain_in u_chain_in (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .debug_select_i (debug_select_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .inhibit_i      (busy),
    .cmd_o          (cmd),
    .module_id_o    (module_id)
  );

  // Bus debug module
  dbg_bus_module u_bus_module (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .module_id_i    (module_id),
    .cmd_i          (cmd),
    .busy_o         (busy),
    .resp_o         (resp),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_o       (wb_dat_o),
    .wb_sel_o       (wb_sel_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .wb_err_i       (wb_err_i)
  );

  // Output side
  dbg_chain_out u_chain_out (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .debug_select_i (debug_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .module_id_i    (module_id),
    .resp_i         (resp),
    .tdo_o          (tdo_o)
  );

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
// Testbench checker: Wishbone request checks, TDO response reassembly, mismatch count
`include "dbg_settings.svh"
`default_nettype none

module tb_checker (
  input  wire                      tck_i,
  input  wire                      tlr_i,
  // DUT Wishbone master side
  input  wire                      wb_cyc_i,
  input  wire                      wb_stb_i,
  input  wire                      wb_we_i,
  input  wire [`DBG_ADDR_W-1:0]    wb_adr_i,
  input  wire [`DBG_DATA_W-1:0]    wb_dat_i,
  input  wire [`DBG_DATA_W/8-1:0]  wb_sel_i,
  // Serial response, collect marks the 34 shift edges
  input  wire                      tdo_i,
  input  wire                      collect_i,
  // Current stimulus row
  input  wire [63:0]               name_i,
  input  wire                      exp_we_i,
  input  wire [`DBG_ADDR_W-1:0]    exp_adr_i,
  input  wire [`DBG_DATA_W-1:0]    exp_dat_i,
  input  wire [`DBG_DATA_W-1:0]    exp_rdata_i,
  input  wire                      exp_err_i,
  input  wire [1:0]                exp_cycles_i,
  input  wire                      new_row_i,
  input  wire                      check_i,
  // Reassembled response and mismatch count
  output logic [`DBG_RESP_LEN-1:0] resp_o,
  output int                       errors_o
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // State
  //////////////////////////////

  logic                     cyc_q;
  // Cycles seen since the row started
  int                       cycles;
  // Busy 0 at the end of every checked row
  logic [`DBG_RESP_LEN-1:0] exp_resp;

  assign exp_resp = {exp_rdata_i, exp_err_i, 1'b0};

  task automatic report(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("ERROR %0s %0s: expected %0h, actual %0h", name_i, what, exp, act);
    errors_o = errors_o + 1;
  endtask

  //////////////////////////////
  // Compare
  //////////////////////////////

  always @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      cyc_q    <= 1'b0;
      cycles   <= 0;
      resp_o   <= '0;
      errors_o = 0;
    end else begin
      cyc_q <= wb_cyc_i;
      if (new_row_i) begin
        cycles <= 0;
      end
      // Request fields at the first edge of a cycle
      if (wb_cyc_i && !cyc_q) begin
        cycles <= cycles + 1;
        if (wb_stb_i !== 1'b1) report("wb_stb", 1, wb_stb_i);
        if (wb_we_i !== exp_we_i) report("wb_we", exp_we_i, wb_we_i);
        if (wb_adr_i !== exp_adr_i) report("wb_adr", exp_adr_i, wb_adr_i);
        if (wb_sel_i !== '1) report("wb_sel", 4'hf, wb_sel_i);
        if (exp_we_i && (wb_dat_i !== exp_dat_i)) report("wb_dat", exp_dat_i, wb_dat_i);
      end
      // LSB first, so bits enter at the top
      if (collect_i) begin
        resp_o <= {tdo_i, resp_o[`DBG_RESP_LEN-1:1]};
      end
      if (check_i) begin
        if (resp_o !== exp_resp) report("response", exp_resp, resp_o);
        if (cycles !== exp_cycles_i) report("bus cycles", exp_cycles_i, cycles);
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
// Testbench top: clock, reset, TAP state driver, Wishbone slave model, stimulus table
`include "dbg_settings.svh"
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int POLL_MAX = 20;
  localparam int WAIT_MAX = 50;
  localparam int NROWS    = 15;
  // Row kinds
  localparam logic [2:0] K_SELECT = 3'd0;
  localparam logic [2:0] K_WRITE  = 3'd1;
  localparam logic [2:0] K_READ   = 3'd2;
  localparam logic [2:0] K_POLL   = 3'd3;
  localparam logic [2:0] K_HELD   = 3'd4;
  // Bus opcodes in the chain word
  localparam logic [1:0] OPC_WRITE = 2'd1;
  localparam logic [1:0] OPC_READ  = 2'd2;
  // Second write sent while the first one hangs
  localparam logic [15:0] DROP_ADR = 16'h000E;

  typedef struct packed {
    logic [63:0] name;
    logic [2:0]  kind;
    logic [15:0] addr;
    // Module ID in bits 1..0 for select rows
    logic [31:0] data;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [1:0]  exp_cycles;
  } row_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic        tck;
  logic        tlr;
  logic        tdi;
  logic        tdo;
  logic        debug_select;
  logic        shift_dr;
  logic        update_dr;
  logic        capture_dr;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic [3:0]  wb_sel;
  logic [31:0] wb_rdat;
  logic        wb_ack;
  logic        wb_err;
  // Checker handshake
  row_t        stim [NROWS];
  row_t        cur;
  logic        new_row;
  logic        check;
  logic        collect;
  logic [33:0] resp;
  int          mismatches;
  int          timeouts;
  // Slave model
  logic [31:0] mem [16];
  logic [2:0]  delay_tab [32];
  logic [4:0]  xfer_idx;
  logic [2:0]  wait_cnt;
  logic        pending;
  logic        hold_ack;

  always #50 tck = ~tck;

  dbg_top dut_i (
    .tck_i (tck), .tlr_i (tlr), .tdi_i (tdi), .tdo_o (tdo),
    .debug_select_i (debug_select), .shift_dr_i (shift_dr),
    .update_dr_i (update_dr), .capture_dr_i (capture_dr),
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
    .wb_dat_o (wb_dat_o), .wb_sel_o (wb_sel), .wb_dat_i (wb_rdat),
    .wb_ack_i (wb_ack), .wb_err_i (wb_err)
  );

  tb_checker u_checker (
    .tck_i (tck), .tlr_i (tlr), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_o), .wb_sel_i (wb_sel),
    .tdo_i (tdo), .collect_i (collect), .name_i (cur.name),
    .exp_we_i ((cur.kind == K_WRITE) || (cur.kind == K_HELD)),
    .exp_adr_i (cur.addr), .exp_dat_i (cur.data), .exp_rdata_i (cur.exp_rdata),
    .exp_err_i (cur.exp_err), .exp_cycles_i (cur.exp_cycles),
    .new_row_i (new_row), .check_i (check), .resp_o (resp), .errors_o (mismatches)
  );

  //////////////////////////////
  // Wishbone slave
  //////////////////////////////

  // Random wait per transfer, err above 0xF000, hold_ack stalls forever
  always @(posedge tck or posedge tlr) begin
    if (tlr) begin
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
      pending  <= 1'b0;
      wait_cnt <= '0;
      xfer_idx <= '0;
    end else begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
        if (!pending) begin
          pending  <= 1'b1;
          wait_cnt <= delay_tab[xfer_idx];
          xfer_idx <= xfer_idx + 1'b1;
        end else if (wait_cnt != 0) begin
          wait_cnt <= wait_cnt - 1'b1;
        end else if (!hold_ack) begin
          pending <= 1'b0;
          if (wb_adr >= 16'hF000) begin
            wb_err <= 1'b1;
          end else begin
            wb_ack <= 1'b1;
            if (wb_we) mem[wb_adr[3:0]] <= wb_dat_o;
            else wb_rdat <= mem[wb_adr[3:0]];
          end
        end
      end
    end
  end

  //////////////////////////////
  // TAP sequences
  //////////////////////////////

  // 51 bits LSB first, then one update pulse
  task automatic shift_cmd(input logic [`DBG_DATAREG_LEN-1:0] word);
    int i;
    for (i = 0; i < `DBG_DATAREG_LEN; i++) begin
      @(posedge tck);
      tdi      <= word[i];
      shift_dr <= 1'b1;
    end
    @(posedge tck);
    tdi       <= 1'b0;
    shift_dr  <= 1'b0;
    update_dr <= 1'b1;
    @(posedge tck);
    update_dr <= 1'b0;
  endtask

  // Capture then 34 shifts; resp valid on return
  task automatic read_resp();
    @(posedge tck);
    capture_dr <= 1'b1;
    @(posedge tck);
    capture_dr <= 1'b0;
    shift_dr   <= 1'b1;
    collect    <= 1'b1;
    repeat (`DBG_RESP_LEN) @(posedge tck);
    shift_dr <= 1'b0;
    collect  <= 1'b0;
    @(posedge tck);
  endtask

  task automatic poll_idle();
    int tries;
    tries = 0;
    read_resp();
    while (resp[0] && tries < POLL_MAX) begin
      read_resp();
      tries++;
    end
    if (resp[0]) begin
      $display("Timeout in %0s: debug module still busy after %0d polls", cur.name, tries);
      timeouts++;
    end
  endtask

  task automatic wait_cyc();
    int n;
    n = 0;
    while (!wb_cyc && n < WAIT_MAX) begin
      @(posedge tck);
      n++;
    end
    if (!wb_cyc) begin
      $display("Timeout in %0s: no Wishbone cycle started", cur.name);
      timeouts++;
    end
  endtask

  task automatic check_row();
    @(posedge tck);
    check <= 1'b1;
    @(posedge tck);
    check <= 1'b0;
  endtask

  // Slave stalled, then a second write and a select while busy
  task automatic run_held();
    @(posedge tck);
    hold_ack <= 1'b1;
    shift_cmd({1'b0, OPC_WRITE, cur.addr, cur.data});
    wait_cyc();
    shift_cmd({1'b0, OPC_WRITE, DROP_ADR, 32'hDEAD_000E});
    shift_cmd({1'b1, `DBG_ID_CPU, 48'h0});
    @(posedge tck);
    hold_ack <= 1'b0;
    poll_idle();
    check_row();
  endtask

  function automatic row_t make_row(input logic [63:0] name, input logic [2:0] kind,
      input logic [15:0] addr, input logic [31:0] data, input logic [31:0] exp_rdata,
      input logic exp_err, input logic [1:0] exp_cycles);
    row_t row;
    row.name       = name;
    row.kind       = kind;
    row.addr       = addr;
    row.data       = data;
    row.exp_rdata  = exp_rdata;
    row.exp_err    = exp_err;
    row.exp_cycles = exp_cycles;
    return row;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int i;
    int r;
    void'($urandom(86));
    for (i = 0; i < 32; i++) begin
      delay_tab[i] = $urandom % 6;
    end
    // Fill pattern carries the word index
    for (i = 0; i < 16; i++) begin
      mem[i] = 32'hC0DE_0000 | i;
    end
    tck          = 1'b0;
    tlr          = 1'b1;
    tdi          = 1'b0;
    debug_select = 1'b0;
    shift_dr     = 1'b0;
    update_dr    = 1'b0;
    capture_dr   = 1'b0;
    wb_rdat      = '0;
    wb_ack       = 1'b0;
    wb_err       = 1'b0;
    hold_ack     = 1'b0;
    new_row      = 1'b0;
    check        = 1'b0;
    collect      = 1'b0;
    cur          = '0;
    timeouts     = 0;
    // Name, kind, addr, data or ID, rdata, err, cycles
    stim[0]  = make_row("rst_resv", K_POLL, 16'h0, 32'h0, 32'h0, 1'b0, 2'd0);
    stim[1]  = make_row("sel_bus", K_SELECT, 16'h0, `DBG_ID_BUS, 32'h0, 1'b0, 2'd0);
    stim[2]  = make_row("wr_a", K_WRITE, 16'h0004, 32'hA5A5_1234, 32'h0, 1'b0, 2'd1);
    stim[3]  = make_row("wr_b", K_WRITE, 16'h0009, 32'h0BAD_F00D, 32'h0, 1'b0, 2'd1);
    stim[4]  = make_row("rd_a", K_READ, 16'h0004, 32'h0, 32'hA5A5_1234, 1'b0, 2'd1);
    stim[5]  = make_row("rd_b", K_READ, 16'h0009, 32'h0, 32'h0BAD_F00D, 1'b0, 2'd1);
    stim[6]  = make_row("rd_err", K_READ, 16'hF010, 32'h0, 32'h0BAD_F00D, 1'b1, 2'd1);
    stim[7]  = make_row("wr_clr", K_WRITE, 16'h0002, 32'h1357_9BDF, 32'h0BAD_F00D, 1'b0, 2'd1);
    stim[8]  = make_row("rd_clr", K_READ, 16'h0002, 32'h0, 32'h1357_9BDF, 1'b0, 2'd1);
    stim[9]  = make_row("wr_err", K_WRITE, 16'hF800, 32'h1, 32'h1357_9BDF, 1'b1, 2'd1);
    stim[10] = make_row("held_wr", K_HELD, 16'h0007, 32'h7E57_0007, 32'h1357_9BDF, 1'b0, 2'd1);
    stim[11] = make_row("rd_held", K_READ, 16'h0007, 32'h0, 32'h7E57_0007, 1'b0, 2'd1);
    stim[12] = make_row("rd_drop", K_READ, DROP_ADR, 32'h0, 32'hC0DE_000E, 1'b0, 2'd1);
    // Bus response is nonzero here, so the CPU module must block it
    stim[13] = make_row("sel_cpu", K_SELECT, 16'h0, `DBG_ID_CPU, 32'h0, 1'b0, 2'd0);
    stim[14] = make_row("cpu_tdo", K_POLL, 16'h0, 32'h0, 32'h0, 1'b0, 2'd0);
    repeat (16) @(posedge tck);
    tlr          <= 1'b0;
    debug_select <= 1'b1;
    for (r = 0; r < NROWS; r++) begin
      @(posedge tck);
      cur     <= stim[r];
      new_row <= 1'b1;
      @(posedge tck);
      new_row <= 1'b0;
      case (cur.kind)
        K_SELECT: shift_cmd({1'b1, cur.data[1:0], 48'h0});
        K_WRITE: begin
          shift_cmd({1'b0, OPC_WRITE, cur.addr, cur.data});
          poll_idle();
          check_row();
        end
        K_READ: begin
          shift_cmd({1'b0, OPC_READ, cur.addr, 32'h0});
          poll_idle();
          check_row();
        end
        K_HELD: run_held();
        default: begin
          poll_idle();
          check_row();
        end
      endcase
    end
    repeat (2) @(posedge tck);
    $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/dbg_pkg.sv
design/dbg_chain_in.sv
design/dbg_bus_module.sv
design/dbg_chain_out.sv
design/dbg_top.sv
sim/tb_checker.sv
sim/tb_top.sv
